// File: tb/read_modes_stim.txt
# backward content forward logits in hex Q4.12, then expected
# weights backward content forward in decimal Q0.16
0000 0000 0000 21845 21845 21845
1000 0000 0000 37755 13889 13889
0000 1000 0000 13889 37755 13889
0000 0000 1000 13889 13889 37755
0000 8000 8000 65485 24 24
7fff 8000 7fff 32761 12 32761
0000 0200 0000 20916 23701 20916
2000 2000 2000 21845 21845 21845
f000 f000 f000 21845 21845 21845
3000 2000 2000 37755 13889 13889
2000 3000 2000 13889 37755 13889
2000 2000 3000 13889 13889 37755
f000 f200 f000 20916 23701 20916
8000 0000 8000 24 65485 24
8000 8000 7fff 24 24 65485
8000 8000 8000 21845 21845 21845

// File: src.f
logic/dnc_fixed_pkg.sv
logic/dnc_stream_pkg.sv
logic/dnc_credit_fifo.sv
logic/dnc_exp_table.sv
logic/dnc_mode_softmax.sv
logic/dnc_read_modes_cfg.sv
logic/dnc_read_modes.sv
tb/tb_dnc_read_modes.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the read-mode softmax testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f src.f --top-module tb_dnc_read_modes -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// File: tb/tb_dnc_read_modes.sv
`timescale 1ns/1ps
// Testbench for the read-mode softmax top driven by the stim file
// Upstream credit model, downstream credit return, register checks

module tb_dnc_read_modes;

  import dnc_stream_pkg::*;

  localparam int IN_DEPTH    = 4;
  localparam int OUT_DEPTH   = 4;
  localparam int OUT_CREDITS = 2;
  localparam int MAX_VEC     = 32;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logit_vec_t  in_data;
  logic        in_credit;
  logic        out_valid;
  weight_vec_t out_data;
  logic        out_credit;
  logic        cfg_we;
  logic        cfg_addr;
  cfg_word_t   cfg_wdata;
  cfg_word_t   cfg_rdata;

  logit_vec_t  vec_mem [MAX_VEC];
  logic [15:0] w_mem [MAX_VEC][3];
  weight_vec_t rx_mem [MAX_VEC];
  int n_file = 0;
  int n_total = 0;
  int send_limit = 0;
  int sent = 0;
  int in_cnt = IN_DEPTH;
  int in_ret = 0;
  int rx_count = 0;
  int owed = 0;
  int credit_err = 0;
  int test_err = 0;
  int pass_count = 0;
  int fail_count = 0;
  bit hold_credits = 1'b1;
  integer seed = 32'h251c_8cad;

  dnc_read_modes #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_DEPTH   (OUT_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) UUT (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_data(in_data),
    .in_credit(in_credit), .out_valid(out_valid), .out_data(out_data),
    .out_credit(out_credit), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_eq(input string name, input longint expected, input longint actual);
    if (expected != actual) begin
      $display("[ERROR] %s expected %0d actual %0d", name, expected, actual);
      test_err++;
    end
  endtask

  task automatic close_test(input string name);
    if (test_err == 0) begin
      pass_count++;
      $display("[PASS] %s", name);
    end else begin
      fail_count++;
      $display("[FAIL] %s (%0d errors)", name, test_err);
    end
    test_err = 0;
  endtask

  task automatic reg_write(input logic addr, input cfg_word_t data);
    @(posedge clk);
    #1 cfg_we = 1'b1;
    cfg_addr = addr;
    cfg_wdata = data;
    @(posedge clk);
    #1 cfg_we = 1'b0;
  endtask

  task automatic reg_read(input logic addr, output cfg_word_t data);
    @(posedge clk);
    #1 cfg_addr = addr;
    @(posedge clk);
    @(negedge clk);
    data = cfg_rdata;
  endtask

  task automatic load_stim();
    int fd;
    int b;
    int c;
    int f;
    int w0;
    int w1;
    int w2;
    string line;
    fd = $fopen("tb/read_modes_stim.txt", "r");
    if (fd == 0) begin
      $display("Stimulus file tb/read_modes_stim.txt could not be opened");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      // Comment lines start with #
      if (line.len() > 0 && line.getc(0) != "#" &&
          $sscanf(line, "%h %h %h %d %d %d", b, c, f, w0, w1, w2) == 6) begin
        vec_mem[n_file] = '{backward: 16'(b), content: 16'(c), forward: 16'(f)};
        w_mem[n_file][0] = 16'(w0);
        w_mem[n_file][1] = 16'(w1);
        w_mem[n_file][2] = 16'(w2);
        n_file++;
      end
    end
    $fclose(fd);
    // Two extra copies of the first vector for the enable test
    for (int k = 0; k < 2; k++) begin
      vec_mem[n_file + k] = vec_mem[0];
      w_mem[n_file + k] = w_mem[0];
    end
    n_total = n_file + 2;
  endtask

  // Upstream sender spending one credit per vector
  initial begin
    in_valid = 1'b0;
    in_data = '0;
    forever begin
      @(posedge clk);
      #1;
      if (rst_n && sent < send_limit && in_cnt > 0) begin
        in_valid = 1'b1;
        in_data = vec_mem[sent];
        sent++;
        in_cnt--;
      end else begin
        in_valid = 1'b0;
      end
    end
  end

  // Receive side and input credit return sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n && in_credit) begin
      in_cnt++;
      in_ret++;
      if (in_ret > sent) begin
        $display("Input credits returned (%0d) exceed vectors sent (%0d)", in_ret, sent);
        credit_err++;
      end
    end
    if (rst_n && out_valid) begin
      if (rx_count < MAX_VEC) begin
        rx_mem[rx_count] = out_data;
      end
      rx_count++;
      owed++;
    end
  end

  // Downstream credit return after a random delay
  initial begin
    int delay;
    delay = 0;
    out_credit = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (!hold_credits && owed > 0 && delay == 0) begin
        out_credit = 1'b1;
        owed--;
        delay = $random(seed) & 3;
      end else begin
        out_credit = 1'b0;
        if (delay > 0) begin
          delay--;
        end
      end
    end
  end

  // Watchdog sized from the vector count
  initial begin
    wait (n_total > 0);
    #(n_total * 62 * 4 * 8 + 2000);
    $display("Timeout: %0d of %0d results received", rx_count, n_total);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    cfg_word_t rd;
    real e63_r;
    longint e63;
    longint clamp_sum;
    longint eq;
    rst_n = 1'b0;
    cfg_we = 1'b0;
    cfg_addr = 1'b0;
    cfg_wdata = '0;
    load_stim();
    if (n_file < 5) begin
      $display("Stimulus file holds too few vectors");
      fail_count++;
    end
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // Reset state
    @(negedge clk);
    check_eq("reset_in_credit", 0, longint'(in_credit));
    check_eq("reset_out_valid", 0, longint'(out_valid));
    check_eq("reset_busy", 0, longint'(UUT.u_softmax.busy));
    check_eq("reset_rdata", 0, longint'(cfg_rdata));
    reg_read(1'b0, rd);
    check_eq("reset_ctrl", 1, longint'(rd));
    close_test("reset_state");

    // Four heads enabled and all vectors sent while credits are held
    reg_write(1'b0, 16'h0007);
    send_limit = n_file;
    repeat (400) @(posedge clk);
    if (rx_count > OUT_CREDITS) begin
      $display("[ERROR] back_pressure expected %0d actual %0d", OUT_CREDITS, rx_count);
      test_err++;
    end
    hold_credits = 1'b0;
    while (rx_count < n_file) @(posedge clk);
    close_test("back_pressure");

    // Equal logits with the expected value taken from the rule
    eq = (64'd65535 * 64'd65535) / 64'd196605;
    for (int p = 0; p < 3; p++) begin
      check_eq("equal_logits", eq, longint'(rx_mem[0][16*(2-p)+5 +: 16]));
    end
    close_test("equal_logits");

    // Line 4 differs by 8.0 and reads table entry 63
    e63_r = 65535.0 * $exp(-63.0 / 8.0);
    e63 = longint'($rtoi(e63_r + 0.5));
    clamp_sum = 65535 + 2 * e63;
    check_eq("clamp_backward", (64'd65535 * 64'd65535) / clamp_sum,
             longint'(rx_mem[4].backward));
    check_eq("clamp_content", (e63 * 65535) / clamp_sum, longint'(rx_mem[4].content));
    check_eq("clamp_forward", (e63 * 65535) / clamp_sum, longint'(rx_mem[4].forward));
    close_test("clamp");

    for (int k = 0; k < n_file; k++) begin
      check_eq($sformatf("vec%0d_backward", k), longint'(w_mem[k][0]),
               longint'(rx_mem[k].backward));
      check_eq($sformatf("vec%0d_content", k), longint'(w_mem[k][1]),
               longint'(rx_mem[k].content));
      check_eq($sformatf("vec%0d_forward", k), longint'(w_mem[k][2]),
               longint'(rx_mem[k].forward));
    end
    close_test("stim_vectors");

    ////////////////////////////////////////////////////////////////////////////
    // Enable gate holding two more vectors until enable returns
    reg_write(1'b0, 16'h0006);
    send_limit = n_total;
    repeat (300) @(posedge clk);
    check_eq("enable_off_results", longint'(n_file), longint'(rx_count));
    reg_write(1'b0, 16'h0007);
    while (rx_count < n_total) @(posedge clk);
    for (int k = n_file; k < n_total; k++) begin
      check_eq("enable_on_content", longint'(w_mem[k][1]), longint'(rx_mem[k].content));
    end
    close_test("enable_gate");

    // Head tags and finished count
    for (int k = 0; k < n_total; k++) begin
      check_eq($sformatf("head%0d", k), longint'(k % 4), longint'(rx_mem[k].head));
      check_eq($sformatf("last%0d", k), longint'(k % 4 == 3), longint'(rx_mem[k].last));
    end
    reg_read(1'b1, rd);
    check_eq("done_count", longint'(rx_count), longint'(rd));
    close_test("head_cycle");

    repeat (20) @(posedge clk);
    test_err = test_err + credit_err;
    check_eq("in_credits_total", longint'(sent), longint'(in_ret));
    close_test("credit_return");

    $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: logic/dnc_read_modes.sv
`timescale 1ns/1ps
// Read-mode softmax top: input and output FIFOs, core, register block
// Output credit counter toward the downstream

module dnc_read_modes #(
  parameter int IN_DEPTH    = 4,
  parameter int OUT_DEPTH   = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        in_valid,
  input  dnc_stream_pkg::logit_vec_t  in_data,
  output logic                        in_credit,
  output logic                        out_valid,
  output dnc_stream_pkg::weight_vec_t out_data,
  input  logic                        out_credit,
  input  logic                        cfg_we,
  input  logic                        cfg_addr,
  input  dnc_stream_pkg::cfg_word_t   cfg_wdata,
  output dnc_stream_pkg::cfg_word_t   cfg_rdata
);

  import dnc_stream_pkg::*;

  localparam int CRED_W = $clog2(OUT_CREDITS + 1);

  // Core input side
  logic        core_valid;
  logit_vec_t  core_data;
  logic        core_pop;
  // Core output side
  logic        res_push;
  weight_vec_t res_data;
  logic        res_full;
  logic        res_valid;

  cfg_t              cfg;
  logic              vec_done;
  logic [CRED_W-1:0] credit_cnt;

  // Upstream owns IN_DEPTH credits, so no push sees a full FIFO
  dnc_credit_fifo #(
    .DEPTH  (IN_DEPTH),
    .item_t (logit_vec_t)
  ) u_in_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (in_valid),
    .push_data (in_data),
    .full      (),
    .pop       (core_pop),
    .pop_data  (core_data),
    .valid     (core_valid),
    .credit    (in_credit)
  );

  dnc_mode_softmax u_softmax (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .in_valid  (core_valid),
    .in_data   (core_data),
    .in_pop    (core_pop),
    .out_ready (!res_full),
    .out_push  (res_push),
    .out_data  (res_data),
    .vec_done  (vec_done)
  );

  dnc_credit_fifo #(
    .DEPTH  (OUT_DEPTH),
    .item_t (weight_vec_t)
  ) u_out_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (res_push),
    .push_data (res_data),
    .full      (res_full),
    .pop       (out_valid),
    .pop_data  (out_data),
    .valid     (res_valid),
    .credit    ()
  );

  dnc_read_modes_cfg u_cfg (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .vec_done  (vec_done),
    .cfg       (cfg)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Downstream credits, spend and return may coincide

  assign out_valid = res_valid && (credit_cnt != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_cnt <= CRED_W'(OUT_CREDITS);
    end else begin
      credit_cnt <= credit_cnt - CRED_W'(out_valid) + CRED_W'(out_credit);
    end
  end

endmodule

// File: logic/dnc_read_modes_cfg.sv
`timescale 1ns/1ps
// Control register, finished-vector counter and registered readback

module dnc_read_modes_cfg (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cfg_we,
  input  logic                      cfg_addr,
  input  dnc_stream_pkg::cfg_word_t cfg_wdata,
  output dnc_stream_pkg::cfg_word_t cfg_rdata,
  input  logic                      vec_done,
  output dnc_stream_pkg::cfg_t      cfg
);

  import dnc_stream_pkg::*;

  localparam int WORD_W = $bits(cfg_word_t);

  cfg_word_t done_cnt;
  cfg_word_t rd_mux;

  // Address 1 is the counter, read only
  assign rd_mux = (cfg_addr == CFG_ADDR_COUNT) ? done_cnt :
                  {{(WORD_W - CFG_W){1'b0}}, cfg};

  ////////////////////////////////////////////////////////////////////////////
  // Control register

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg <= CFG_RESET;
    end else if (cfg_we && cfg_addr == CFG_ADDR_CTRL) begin
      cfg <= cfg_t'(cfg_wdata[CFG_W-1:0]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Finished vectors and readback

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_cnt  <= '0;
      cfg_rdata <= '0;
    end else begin
      // Rolls over at 16 bits
      if (vec_done) begin
        done_cnt <= done_cnt + 1'b1;
      end
      cfg_rdata <= rd_mux;
    end
  end

endmodule

// File: logic/dnc_mode_softmax.sv
`timescale 1ns/1ps
// Sequential softmax over one three-mode logit vector
// Max, table exponentials, sum, serial restoring divide, push

module dnc_mode_softmax (
  input  logic                        clk,
  input  logic                        rst_n,
  input  dnc_stream_pkg::cfg_t        cfg,
  input  logic                        in_valid,
  input  dnc_stream_pkg::logit_vec_t  in_data,
  output logic                        in_pop,
  input  logic                        out_ready,
  output logic                        out_push,
  output dnc_stream_pkg::weight_vec_t out_data,
  output logic                        vec_done
);

  import dnc_fixed_pkg::*;
  import dnc_stream_pkg::*;

  localparam int MODE_W = $clog2(NUM_MODES);
  localparam int STEP_W = $clog2(DIV_STEPS);
  localparam int REM_W  = $bits(exp_sum_t);
  localparam int W_W    = $bits(weight_t);

  typedef enum logic [2:0] {
    S_IDLE, S_MAX, S_EXP, S_SUM, S_DIV, S_PUSH
  } state_t;

  state_t            state;
  logic              busy;
  logic [MODE_W-1:0] mode_idx;
  logic [STEP_W-1:0] step_cnt;
  head_t             head_q;

  logit_t   logit_q  [NUM_MODES];
  weight_t  exp_q    [NUM_MODES];
  weight_t  weight_q [NUM_MODES];
  logit_t   max_q;
  logit_t   max_d;
  exp_sum_t sum_q;
  exp_sum_t sum_d;

  // Table port
  logic [MODE_W-1:0] lut_sel;
  logic [16:0]       diff_wide;
  logit_t            diff_sat;
  weight_t           exp_val;

  // Divider
  logic [REM_W-1:0]      rem_q;
  logic [DIV_STEPS-1:0]  shift_q;
  logic [DIV_STEPS-1:0]  quot_q;
  logic [REM_W:0]        trial;
  logic                  ge;
  logic [REM_W-1:0]      rem_next;
  logic [DIV_STEPS-1:0]  quot_next;
  weight_t               weight_sat;
  logic [MODE_W-1:0]     load_sel;
  logic [DIVIDEND_W-1:0] dividend;
  logic                  div_last;

  // e * 65535 without a multiplier
  function automatic logic [DIVIDEND_W-1:0] scale_one(input weight_t e);
    return (DIVIDEND_W'(e) << W_W) - DIVIDEND_W'(e);
  endfunction

  assign busy     = (state != S_IDLE);
  assign in_pop   = !busy && in_valid && cfg.enable;
  assign out_push = (state == S_PUSH) && out_ready;
  assign vec_done = out_push;

  ////////////////////////////////////////////////////////////////////////////
  // Max, difference and sum

  always_comb begin
    max_d = logit_q[0];
    sum_d = '0;
    for (int p = 1; p < NUM_MODES; p++) begin
      if (logit_q[p] > max_d) begin
        max_d = logit_q[p];
      end
    end
    for (int p = 0; p < NUM_MODES; p++) begin
      sum_d = sum_d + exp_sum_t'(exp_q[p]);
    end
  end

  // Step 3 of the lookup only drains, selector parks on 0
  assign lut_sel   = (step_cnt < STEP_W'(NUM_MODES)) ? step_cnt[MODE_W-1:0] : '0;
  assign diff_wide = {logit_q[lut_sel][15], logit_q[lut_sel]} - {max_q[15], max_q};
  // Below -8.0 saturates, table clamps anyway
  assign diff_sat  = (diff_wide[16] != diff_wide[15]) ? 16'sh8000 : diff_wide[15:0];

  dnc_exp_table u_exp_table (
    .clk     (clk),
    .diff    (diff_sat),
    .exp_val (exp_val)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Restoring division, one quotient bit per cycle

  assign trial      = {rem_q, shift_q[DIV_STEPS-1]};
  assign ge         = (trial >= {1'b0, sum_q});
  assign rem_next   = ge ? REM_W'(trial - {1'b0, sum_q}) : trial[REM_W-1:0];
  assign quot_next  = {quot_q[DIV_STEPS-2:0], ge};
  assign weight_sat = (|quot_next[DIV_STEPS-1:W_W]) ? WEIGHT_ONE : quot_next[W_W-1:0];
  assign div_last   = (step_cnt == STEP_W'(DIV_STEPS - 1));

  // Next dividend: mode 0 from the sum cycle, else the following mode
  assign load_sel = (state == S_SUM || mode_idx == MODE_W'(NUM_MODES - 1)) ? '0 :
                    mode_idx + 1'b1;
  assign dividend = scale_one(exp_q[load_sel]);

  ////////////////////////////////////////////////////////////////////////////
  // FSM

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      mode_idx <= '0;
      step_cnt <= '0;
      head_q   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (in_pop) begin
            state <= S_MAX;
          end
        end
        S_MAX: begin
          state    <= S_EXP;
          step_cnt <= '0;
        end
        // Three issues, one drain cycle
        S_EXP: begin
          if (step_cnt == STEP_W'(NUM_MODES)) begin
            state    <= S_SUM;
            step_cnt <= '0;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        S_SUM: begin
          state    <= S_DIV;
          mode_idx <= '0;
          step_cnt <= '0;
        end
        S_DIV: begin
          if (div_last) begin
            step_cnt <= '0;
            if (mode_idx == MODE_W'(NUM_MODES - 1)) begin
              state <= S_PUSH;
            end else begin
              mode_idx <= mode_idx + 1'b1;
            end
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        // Holds here while the output FIFO is full
        S_PUSH: begin
          if (out_ready) begin
            state  <= S_IDLE;
            head_q <= (head_q >= cfg.num_heads) ? '0 : head_q + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge clk) begin
    case (state)
      S_IDLE: begin
        if (in_pop) begin
          logit_q[0] <= in_data.backward;
          logit_q[1] <= in_data.content;
          logit_q[2] <= in_data.forward;
        end
      end
      S_MAX: max_q <= max_d;
      S_EXP: begin
        // Lookup result lags its issue by one cycle
        if (step_cnt != '0) begin
          exp_q[MODE_W'(step_cnt - 1'b1)] <= exp_val;
        end
      end
      S_SUM: begin
        sum_q   <= sum_d;
        rem_q   <= REM_W'(dividend[DIVIDEND_W-1:DIV_STEPS]);
        shift_q <= dividend[DIV_STEPS-1:0];
        quot_q  <= '0;
      end
      S_DIV: begin
        if (div_last) begin
          weight_q[mode_idx] <= weight_sat;
          rem_q   <= REM_W'(dividend[DIVIDEND_W-1:DIV_STEPS]);
          shift_q <= dividend[DIV_STEPS-1:0];
          quot_q  <= '0;
        end else begin
          rem_q   <= rem_next;
          shift_q <= shift_q << 1;
          quot_q  <= quot_next;
        end
      end
      default: ;
    endcase
  end

  // Result with head tag
  always_comb begin
    out_data.backward = weight_q[0];
    out_data.content  = weight_q[1];
    out_data.forward  = weight_q[2];
    out_data.head     = head_q;
    out_data.last     = (head_q == cfg.num_heads);
  end

endmodule

// File: logic/dnc_exp_table.sv
`timescale 1ns/1ps
// Registered e^x lookup for a non-positive Q4.12 difference

module dnc_exp_table (
  input  logic                   clk,
  input  dnc_fixed_pkg::logit_t  diff,
  output dnc_fixed_pkg::weight_t exp_val
);

  import dnc_fixed_pkg::*;

  localparam int COARSE_W = 17 - EXP_STEP_SHIFT;

  logic [16:0]          mag;
  logic [COARSE_W-1:0]  coarse;
  logic [EXP_IDX_W-1:0] idx;

  // Magnitude of the difference, 17 bits so -32768 stays exact
  assign mag    = 17'd0 - {diff[15], diff};
  // Whole 1/8 steps
  assign coarse = mag[16:EXP_STEP_SHIFT];

  always_comb begin
    if (!diff[15]) begin
      // Zero or positive difference reads entry 0
      idx = '0;
    end else if (coarse > COARSE_W'(EXP_ENTRIES - 1)) begin
      // Past 63/8 clamp to the last entry
      idx = EXP_IDX_W'(EXP_ENTRIES - 1);
    end else begin
      idx = coarse[EXP_IDX_W-1:0];
    end
  end

  // One-cycle lookup
  always_ff @(posedge clk) begin
    exp_val <= exp_table[idx];
  end

endmodule

// File: logic/dnc_credit_fifo.sv
`timescale 1ns/1ps
// Circular-buffer FIFO for any packed payload
// Returns one credit pulse per popped item

module dnc_credit_fifo #(
  parameter int  DEPTH  = 4,
  parameter type item_t = logic [7:0]
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  push,
  input  item_t push_data,
  output logic  full,
  input  logic  pop,
  output item_t pop_data,
  output logic  valid,
  output logic  credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Wrap at DEPTH, so any depth works
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full     = (count == CNT_W'(DEPTH));
  assign valid    = (count != '0);
  assign do_push  = push && !full;
  assign do_pop   = pop && valid;
  assign pop_data = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers, occupancy and credit return
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count  <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      credit <= do_pop;
    end
  end

endmodule

// File: logic/dnc_stream_pkg.sv
// Payload structs for the logit and weight streams
// Configuration record and register map

package dnc_stream_pkg;

  // Read-head index
  typedef logic [3:0] head_t;

  // Mode logits of one read head, backward in the top word
  typedef struct packed {
    dnc_fixed_pkg::logit_t backward;
    dnc_fixed_pkg::logit_t content;
    dnc_fixed_pkg::logit_t forward;
  } logit_vec_t;

  // Mode weights, tagged with head and end of head sweep
  typedef struct packed {
    dnc_fixed_pkg::weight_t backward;
    dnc_fixed_pkg::weight_t content;
    dnc_fixed_pkg::weight_t forward;
    head_t                  head;
    logic                   last;
  } weight_vec_t;

  // Control register, enable in bit 0
  typedef struct packed {
    head_t num_heads;  // heads minus one
    logic  enable;
  } cfg_t;

  localparam int   CFG_W     = $bits(cfg_t);
  localparam cfg_t CFG_RESET = '{num_heads: 4'd0, enable: 1'b1};

  // Register port word and addresses
  typedef logic [15:0] cfg_word_t;
  localparam logic CFG_ADDR_CTRL  = 1'b0;
  localparam logic CFG_ADDR_COUNT = 1'b1;

endpackage

// File: logic/dnc_fixed_pkg.sv
// Fixed-point formats for the read-mode softmax
// Exponential lookup contents and serial divider sizing

package dnc_fixed_pkg;

  // Logit in Q4.12, two's complement
  typedef logic signed [15:0] logit_t;
  localparam int LOGIT_FRAC = 12;

  // Weight in Q0.16, all ones stands for 1.0
  typedef logic [15:0] weight_t;
  localparam weight_t WEIGHT_ONE = 16'hffff;

  // Sum of three exponentials, up to 3 * 65535
  typedef logic [17:0] exp_sum_t;

  localparam int NUM_MODES = 3;

  // Exponential table, one entry per 1/8 step of the difference
  localparam int EXP_ENTRIES = 64;
  localparam int EXP_IDX_W = $clog2(EXP_ENTRIES);
  localparam int EXP_STEP_SHIFT = LOGIT_FRAC - 3;

  // Entry k = round(65535 * e^(-k/8))
  localparam weight_t exp_table [EXP_ENTRIES] = '{
    16'd65535, 16'd57834, 16'd51039, 16'd45042, 16'd39749, 16'd35078, 16'd30957, 16'd27319,
    16'd24109, 16'd21276, 16'd18776, 16'd16570, 16'd14623, 16'd12905, 16'd11388, 16'd10050,
    16'd8869,  16'd7827,  16'd6907,  16'd6096,  16'd5379,  16'd4747,  16'd4190,  16'd3697,
    16'd3263,  16'd2879,  16'd2541,  16'd2242,  16'd1979,  16'd1746,  16'd1541,  16'd1360,
    16'd1200,  16'd1059,  16'd935,   16'd825,   16'd728,   16'd642,   16'd567,   16'd500,
    16'd442,   16'd390,   16'd344,   16'd303,   16'd268,   16'd236,   16'd209,   16'd184,
    16'd162,   16'd143,   16'd127,   16'd112,   16'd99,    16'd87,    16'd77,    16'd68,
    16'd60,    16'd53,    16'd47,    16'd41,    16'd36,    16'd32,    16'd28,    16'd25
  };

  // Restoring divider, e * 65535 over the sum
  localparam int DIVIDEND_W = 32;
  localparam int DIV_STEPS = 18;

endpackage
